/* common/rvPkg.sv */
package rvPkg;

    localparam int xlen = 64;

    localparam logic [6:0] opOp     = 7'b0110011;
    localparam logic [6:0] opOpImm  = 7'b0010011;
    localparam logic [6:0] opOpW    = 7'b0111011;
    localparam logic [6:0] opOpImmW = 7'b0011011;
    localparam logic [6:0] opLui    = 7'b0110111;
    localparam logic [6:0] opAuipc  = 7'b0010111;
    localparam logic [6:0] opJal    = 7'b1101111;
    localparam logic [6:0] opJalr   = 7'b1100111;
    localparam logic [6:0] opBranch = 7'b1100011;
    localparam logic [6:0] opLoad   = 7'b0000011;
    localparam logic [6:0] opStore  = 7'b0100011;
    localparam logic [6:0] opSystem = 7'b1110011;

    typedef enum logic [3:0] {
        aluAdd, aluSub, aluXor, aluOr, aluAnd,
        aluSll, aluSrl, aluSlt, aluSltu, aluPassB
    } aluOp_t;

    typedef enum logic [1:0] {wbAlu, wbMem, wbPc4} wbSel_t;

    typedef struct packed {
        aluOp_t     aluOp;
        logic       selA;       // 1 rs1, 0 pc
        logic       selB;       // 1 rs2, 0 imm
        logic       wordOp;
        logic       writeRd;
        wbSel_t     wbSel;
        logic       memRead;
        logic       memWrite;
        logic [1:0] memSize;    // log2 of byte count
        logic       loadSigned;
        logic       jumpReg;
        logic       takePc;
        logic       halt;
        logic       illegal;
    } ctrl_t;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rType_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } iType_t;

    typedef struct packed {
        logic [6:0] immHi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] immLo;
        logic [6:0] opcode;
    } sType_t;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10to5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4to1;
        logic       imm11;
        logic [6:0] opcode;
    } bType_t;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } uType_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10to1;
        logic       imm11;
        logic [7:0] imm19to12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } jType_t;

    typedef union packed {
        rType_t r;
        iType_t i;
        sType_t s;
        bType_t b;
        uType_t u;
        jType_t j;
    } inst_t;

    typedef struct packed {
        logic            cyc;
        logic            stb;
        logic            we;
        logic [xlen-1:0] adr;
        logic [7:0]      sel;
        logic [xlen-1:0] datW;
    } wbMaster_t;

    typedef struct packed {
        logic            ack;
        logic [xlen-1:0] datR;
    } wbSlave_t;

endpackage

/* verilog/decoder.sv */
`timescale 1ns/1ns

module decoder (
    input  rvPkg::inst_t           inst,
    input  logic [rvPkg::xlen-1:0] rs1Data,
    input  logic [rvPkg::xlen-1:0] rs2Data,
    output rvPkg::ctrl_t           ctrl
);

    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       rsEqual;
    logic       rsLess;
    logic       rsLessU;

    assign funct3  = inst.r.funct3;
    assign funct7  = inst.r.funct7;
    assign rsEqual = rs1Data == rs2Data;
    assign rsLess  = $signed(rs1Data) < $signed(rs2Data);
    assign rsLessU = rs1Data < rs2Data;

    // shared by OP and OP-IMM
    function automatic rvPkg::aluOp_t aluFromFunct3(input logic [2:0] f3);
        case (f3)
            3'b001:  return rvPkg::aluSll;
            3'b010:  return rvPkg::aluSlt;
            3'b011:  return rvPkg::aluSltu;
            3'b100:  return rvPkg::aluXor;
            3'b101:  return rvPkg::aluSrl;
            3'b110:  return rvPkg::aluOr;
            3'b111:  return rvPkg::aluAnd;
            default: return rvPkg::aluAdd;
        endcase
    endfunction

    always_comb begin
        ctrl       = '0;
        ctrl.aluOp = rvPkg::aluAdd;
        ctrl.wbSel = rvPkg::wbAlu;
        ctrl.selA  = 1'b1;
        case (inst.r.opcode)
            rvPkg::opOp: begin
                ctrl.selB    = 1'b1;
                ctrl.writeRd = 1'b1;
                ctrl.aluOp   = aluFromFunct3(funct3);
                if (funct3 == 3'b000 && funct7 == 7'h20) begin
                    ctrl.aluOp = rvPkg::aluSub;
                end else if (funct7 != 7'h00) begin
                    ctrl.illegal = 1'b1;    // sra and M ops land here
                end
            end
            rvPkg::opOpImm: begin
                ctrl.writeRd = 1'b1;
                ctrl.aluOp   = aluFromFunct3(funct3);
                if (funct3[1:0] == 2'b01 && funct7[6:1] != 6'h00) begin
                    ctrl.illegal = 1'b1;    // shamt is 6 bits
                end
            end
            rvPkg::opOpW: begin
                ctrl.selB    = 1'b1;
                ctrl.wordOp  = 1'b1;
                ctrl.writeRd = 1'b1;
                if (funct3 != 3'b000 || funct7 != 7'h00) begin
                    ctrl.illegal = 1'b1;    // only addw
                end
            end
            rvPkg::opOpImmW: begin
                ctrl.wordOp  = 1'b1;
                ctrl.writeRd = 1'b1;
                ctrl.illegal = funct3 != 3'b000;
            end
            rvPkg::opLui: begin
                ctrl.aluOp   = rvPkg::aluPassB;
                ctrl.writeRd = 1'b1;
            end
            rvPkg::opAuipc: begin
                ctrl.selA    = 1'b0;
                ctrl.writeRd = 1'b1;
            end
            rvPkg::opJal: begin
                ctrl.writeRd = 1'b1;
                ctrl.wbSel   = rvPkg::wbPc4;
                ctrl.takePc  = 1'b1;
            end
            rvPkg::opJalr: begin
                ctrl.writeRd = 1'b1;
                ctrl.wbSel   = rvPkg::wbPc4;
                ctrl.takePc  = 1'b1;
                ctrl.jumpReg = 1'b1;
                ctrl.illegal = funct3 != 3'b000;
            end
            rvPkg::opBranch: begin
                case (funct3)
                    3'b000:  ctrl.takePc = rsEqual;
                    3'b001:  ctrl.takePc = !rsEqual;
                    3'b100:  ctrl.takePc = rsLess;
                    3'b101:  ctrl.takePc = !rsLess;
                    3'b110:  ctrl.takePc = rsLessU;
                    3'b111:  ctrl.takePc = !rsLessU;
                    default: ctrl.illegal = 1'b1;
                endcase
            end
            rvPkg::opLoad: begin
                ctrl.writeRd    = 1'b1;
                ctrl.wbSel      = rvPkg::wbMem;
                ctrl.memRead    = 1'b1;
                ctrl.memSize    = funct3[1:0];
                ctrl.loadSigned = !funct3[2];
                ctrl.illegal    = funct3[2] && funct3[1];   // no lwu/ldu
            end
            rvPkg::opStore: begin
                ctrl.memWrite = 1'b1;
                ctrl.memSize  = funct3[1:0];
                ctrl.illegal  = funct3[2];
            end
            rvPkg::opSystem: begin
                if (inst == 32'h0010_0073) begin
                    ctrl.halt = 1'b1;   // ebreak
                end else begin
                    ctrl.illegal = 1'b1;
                end
            end
            default: ctrl.illegal = 1'b1;
        endcase

        if (ctrl.illegal) begin
            ctrl.writeRd  = 1'b0;
            ctrl.memRead  = 1'b0;
            ctrl.memWrite = 1'b0;
            ctrl.takePc   = 1'b0;
            ctrl.jumpReg  = 1'b0;
        end
    end

endmodule

/* verilog/immGen.sv */
`timescale 1ns/1ns

module immGen (
    input  rvPkg::inst_t           inst,
    output logic [rvPkg::xlen-1:0] imm
);

    always_comb begin
        case (inst.r.opcode)
            rvPkg::opOpImm, rvPkg::opOpImmW, rvPkg::opLoad, rvPkg::opJalr, rvPkg::opSystem: begin
                imm = {{52{inst.i.imm[11]}}, inst.i.imm};
            end
            rvPkg::opStore: begin
                imm = {{52{inst.s.immHi[6]}}, inst.s.immHi, inst.s.immLo};
            end
            rvPkg::opBranch: begin
                imm = {{52{inst.b.imm12}}, inst.b.imm11, inst.b.imm10to5,
                       inst.b.imm4to1, 1'b0};
            end
            rvPkg::opLui, rvPkg::opAuipc: begin
                imm = {{32{inst.u.imm[19]}}, inst.u.imm, 12'h000};
            end
            rvPkg::opJal: begin
                imm = {{44{inst.j.imm20}}, inst.j.imm19to12, inst.j.imm11,
                       inst.j.imm10to1, 1'b0};
            end
            default: imm = '0;  // R-type has none
        endcase
    end

endmodule

/* verilog/alu.sv */
`timescale 1ns/1ns

module alu (
    input  rvPkg::aluOp_t          op,
    input  logic                   wordOp,
    input  logic [rvPkg::xlen-1:0] a,
    input  logic [rvPkg::xlen-1:0] b,
    output logic [rvPkg::xlen-1:0] result
);

    logic [5:0]             shamt;
    logic [rvPkg::xlen-1:0] shiftSrc;
    logic [rvPkg::xlen-1:0] raw;

    assign shamt    = wordOp ? {1'b0, b[4:0]} : b[5:0];
    assign shiftSrc = wordOp ? {32'h0, a[31:0]} : a;   // word srl fills zeros at bit 31

    always_comb begin
        case (op)
            rvPkg::aluAdd:   raw = a + b;
            rvPkg::aluSub:   raw = a - b;
            rvPkg::aluXor:   raw = a ^ b;
            rvPkg::aluOr:    raw = a | b;
            rvPkg::aluAnd:   raw = a & b;
            rvPkg::aluSll:   raw = a << shamt;
            rvPkg::aluSrl:   raw = shiftSrc >> shamt;
            rvPkg::aluSlt:   raw = {63'h0, $signed(a) < $signed(b)};
            rvPkg::aluSltu:  raw = {63'h0, a < b};
            rvPkg::aluPassB: raw = b;
            default:         raw = '0;
        endcase
    end

    assign result = wordOp ? {{32{raw[31]}}, raw[31:0]} : raw;

endmodule

/* verilog/regFile.sv */
`timescale 1ns/1ns

module regFile (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [4:0]             rs1Addr,
    input  logic [4:0]             rs2Addr,
    input  logic [4:0]             rdAddr,
    input  logic                   writeEnable,
    input  logic [rvPkg::xlen-1:0] rdData,
    output logic [rvPkg::xlen-1:0] rs1Data,
    output logic [rvPkg::xlen-1:0] rs2Data
);

    logic [rvPkg::xlen-1:0] regs [32];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int n = 0; n < 32; n++) begin
                regs[n] <= '0;
            end
        end else if (writeEnable && rdAddr != 5'd0) begin
            regs[rdAddr] <= rdData;
        end
    end

    // x0 reads as zero
    assign rs1Data = (rs1Addr == 5'd0) ? '0 : regs[rs1Addr];
    assign rs2Data = (rs2Addr == 5'd0) ? '0 : regs[rs2Addr];

endmodule

/* verilog/programCounter.sv */
`timescale 1ns/1ns

module programCounter (
    input  logic                   clk,
    input  logic                   reset,
    input  rvPkg::ctrl_t           ctrl,
    input  logic                   busy,
    input  logic [rvPkg::xlen-1:0] imm,
    input  logic [rvPkg::xlen-1:0] rs1Data,
    output logic [rvPkg::xlen-1:0] pc,
    output logic                   halt
);

    logic [rvPkg::xlen-1:0] jumpTarget;
    logic [rvPkg::xlen-1:0] nextPc;

    assign jumpTarget = rs1Data + imm;

    always_comb begin
        if (ctrl.jumpReg) begin
            nextPc = {jumpTarget[rvPkg::xlen-1:1], 1'b0};   // jalr clears bit 0
        end else if (ctrl.takePc) begin
            nextPc = pc + imm;
        end else begin
            nextPc = pc + 64'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc   <= '0;
            halt <= 1'b0;
        end else if (!halt && !busy) begin
            if (ctrl.halt) begin
                halt <= 1'b1;   // pc stays on the ebreak
            end else begin
                pc <= nextPc;
            end
        end
    end

endmodule

/* verilog/loadStoreUnit.sv */
`timescale 1ns/1ns

module loadStoreUnit (
    input  logic                   clk,
    input  logic                   reset,
    input  rvPkg::ctrl_t           ctrl,
    input  logic [rvPkg::xlen-1:0] addr,
    input  logic [rvPkg::xlen-1:0] storeData,
    output rvPkg::wbMaster_t       wbOut,
    input  rvPkg::wbSlave_t        wbIn,
    output logic [rvPkg::xlen-1:0] loadData,
    output logic                   busy
);

    logic                   memOp;
    logic                   request;
    logic                   done;
    logic                   signExt;
    logic [7:0]             byteMask;
    logic [5:0]             laneShift;
    logic [rvPkg::xlen-1:0] laneData;

    assign memOp     = ctrl.memRead | ctrl.memWrite;
    assign request   = memOp & ~done;  // idle one cycle after each ack
    assign busy      = memOp & ~(request & wbIn.ack);
    assign laneShift = {addr[2:0], 3'b000};
    assign signExt   = ctrl.loadSigned;

    always_comb begin
        case (ctrl.memSize)
            2'd0:    byteMask = 8'h01;
            2'd1:    byteMask = 8'h03;
            2'd2:    byteMask = 8'h0F;
            default: byteMask = 8'hFF;
        endcase
    end

    assign wbOut.cyc  = request;
    assign wbOut.stb  = request;
    assign wbOut.we   = request & ctrl.memWrite;
    assign wbOut.adr  = {addr[rvPkg::xlen-1:3], 3'b000};
    assign wbOut.sel  = byteMask << addr[2:0];
    assign wbOut.datW = storeData << laneShift;

    // bring the addressed bytes down to bit 0
    assign laneData = wbIn.datR >> laneShift;

    always_comb begin
        case (ctrl.memSize)
            2'd0:    loadData = {{56{signExt & laneData[7]}}, laneData[7:0]};
            2'd1:    loadData = {{48{signExt & laneData[15]}}, laneData[15:0]};
            2'd2:    loadData = {{32{signExt & laneData[31]}}, laneData[31:0]};
            default: loadData = laneData;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            done <= 1'b0;
        end else begin
            done <= request & wbIn.ack;
        end
    end

endmodule

/* verilog/rvCore.sv */
`timescale 1ns/1ns

module rvCore (
    input  logic                   clk,
    input  logic                   reset,
    output logic [rvPkg::xlen-1:0] instAddr,
    input  rvPkg::inst_t           inst,
    output rvPkg::wbMaster_t       wbOut,
    input  rvPkg::wbSlave_t        wbIn,
    output logic                   halt
);

    rvPkg::ctrl_t           ctrl;
    logic [rvPkg::xlen-1:0] pc;
    logic [rvPkg::xlen-1:0] pcPlus4;
    logic [rvPkg::xlen-1:0] imm;
    logic [rvPkg::xlen-1:0] rs1Data;
    logic [rvPkg::xlen-1:0] rs2Data;
    logic [rvPkg::xlen-1:0] aluA;
    logic [rvPkg::xlen-1:0] aluB;
    logic [rvPkg::xlen-1:0] aluResult;
    logic [rvPkg::xlen-1:0] loadData;
    logic [rvPkg::xlen-1:0] rdData;
    logic                   busy;
    logic                   writeEnable;

    assign instAddr    = pc;
    assign pcPlus4     = pc + 64'd4;
    assign aluA        = ctrl.selA ? rs1Data : pc;
    assign aluB        = ctrl.selB ? rs2Data : imm;
    assign writeEnable = ctrl.writeRd & ~busy & ~halt;

    always_comb begin
        case (ctrl.wbSel)
            rvPkg::wbMem: rdData = loadData;
            rvPkg::wbPc4: rdData = pcPlus4;   // link address
            default:      rdData = aluResult;
        endcase
    end

    decoder decodeUnit (
        .inst    (inst),
        .rs1Data (rs1Data),
        .rs2Data (rs2Data),
        .ctrl    (ctrl)
    );

    immGen immUnit (
        .inst (inst),
        .imm  (imm)
    );

    alu aluUnit (
        .op     (ctrl.aluOp),
        .wordOp (ctrl.wordOp),
        .a      (aluA),
        .b      (aluB),
        .result (aluResult)
    );

    regFile regs (
        .clk         (clk),
        .reset       (reset),
        .rs1Addr     (inst.r.rs1),
        .rs2Addr     (inst.r.rs2),
        .rdAddr      (inst.r.rd),
        .writeEnable (writeEnable),
        .rdData      (rdData),
        .rs1Data     (rs1Data),
        .rs2Data     (rs2Data)
    );

    programCounter pcUnit (
        .clk     (clk),
        .reset   (reset),
        .ctrl    (ctrl),
        .busy    (busy),
        .imm     (imm),
        .rs1Data (rs1Data),
        .pc      (pc),
        .halt    (halt)
    );

    loadStoreUnit lsu (
        .clk       (clk),
        .reset     (reset),
        .ctrl      (ctrl),
        .addr      (aluResult),
        .storeData (rs2Data),
        .wbOut     (wbOut),
        .wbIn      (wbIn),
        .loadData  (loadData),
        .busy      (busy)
    );

endmodule

/* sim/isaModel.svh */
`ifndef ISA_MODEL_SVH
`define ISA_MODEL_SVH

typedef struct packed {
    logic [63:0] adr;
    logic [7:0]  sel;
    logic [63:0] data;
} storeRec_t;

logic [63:0] modelRegs [32];
logic [63:0] modelMem [memWords];
logic [63:0] modelTrace [$];
storeRec_t   expStores [$];
int          modelMemOps;

function automatic logic [63:0] opResult(input logic [2:0] f3, input logic alt,
                                         input logic [63:0] a, input logic [63:0] b);
    case (f3)
        3'd0:    return alt ? a - b : a + b;
        3'd1:    return a << b[5:0];
        3'd2:    return {63'd0, $signed(a) < $signed(b)};
        3'd3:    return {63'd0, a < b};
        3'd4:    return a ^ b;
        3'd5:    return a >> b[5:0];
        3'd6:    return a | b;
        default: return a & b;
    endcase
endfunction

function automatic logic branchTaken(input logic [2:0] f3, input logic [63:0] a,
                                     input logic [63:0] b);
    case (f3)
        3'd0:    return a == b;
        3'd1:    return a != b;
        3'd4:    return $signed(a) < $signed(b);
        3'd5:    return $signed(a) >= $signed(b);
        3'd6:    return a < b;
        default: return a >= b;
    endcase
endfunction

function automatic logic [63:0] loadValue(input logic [63:0] addr, input logic [2:0] f3);
    logic [63:0] v;
    v = modelMem[addr[10:3]] >> {addr[2:0], 3'b000};
    case (f3)
        3'd0:    return {{56{v[7]}}, v[7:0]};
        3'd1:    return {{48{v[15]}}, v[15:0]};
        3'd2:    return {{32{v[31]}}, v[31:0]};
        3'd4:    return {56'd0, v[7:0]};
        3'd5:    return {48'd0, v[15:0]};
        default: return v;
    endcase
endfunction

task automatic storeValue(input logic [63:0] addr, input logic [1:0] size,
                          input logic [63:0] val);
    storeRec_t rec;
    int        lane;
    rec     = '0;
    rec.adr = {addr[63:3], 3'b000};
    for (int k = 0; k < (1 << size); k++) begin
        lane                  = addr[2:0] + k;
        rec.sel[lane]         = 1'b1;
        rec.data[8*lane +: 8] = val[8*k +: 8];
        modelMem[addr[10:3]][8*lane +: 8] = val[8*k +: 8];
    end
    expStores.push_back(rec);
endtask

task automatic runModel();
    logic [31:0] w;
    logic [63:0] pc;
    logic [63:0] next;
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] res;
    logic [63:0] immI;
    logic [63:0] immS;
    logic [63:0] immB;
    logic [63:0] immU;
    logic [63:0] immJ;
    logic        wr;
    pc          = '0;
    modelMemOps = 0;
    modelMem    = dataMem;
    foreach (modelRegs[n]) modelRegs[n] = '0;
    for (int step = 0; step < 4096; step++) begin
        w = progMem[pc[9:2]];
        modelTrace.push_back(pc);
        if (w == ebreakWord) break;
        a    = modelRegs[w[19:15]];
        b    = modelRegs[w[24:20]];
        immI = {{52{w[31]}}, w[31:20]};
        immS = {{52{w[31]}}, w[31:25], w[11:7]};
        immB = {{51{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        immU = {{32{w[31]}}, w[31:12], 12'h000};
        immJ = {{43{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
        next = pc + 64'd4;
        res  = '0;
        wr   = 1'b1;
        case (w[6:0])
            7'h33: res = opResult(w[14:12], w[30], a, b);
            7'h13: res = opResult(w[14:12], 1'b0, a, immI);
            7'h3B: res = a + b;
            7'h1B: res = a + immI;
            7'h37: res = immU;
            7'h17: res = pc + immU;
            7'h6F: begin
                res  = pc + 64'd4;
                next = pc + immJ;
            end
            7'h67: begin
                res  = pc + 64'd4;
                next = (a + immI) & ~64'd1;
            end
            7'h63: begin
                wr = 1'b0;
                if (branchTaken(w[14:12], a, b)) next = pc + immB;
            end
            7'h03: begin
                res = loadValue(a + immI, w[14:12]);
                modelMemOps++;
            end
            default: begin
                wr = 1'b0;
                storeValue(a + immS, w[13:12], b);
                modelMemOps++;
            end
        endcase
        // word forms keep the low 32 bits of the sum
        if (w[6:0] == 7'h3B || w[6:0] == 7'h1B) res = {{32{res[31]}}, res[31:0]};
        if (wr && w[11:7] != 5'd0) modelRegs[w[11:7]] = res;
        pc = next;
    end
endtask

`endif

/* sim/rvCoreTb.sv */
`timescale 1ns/1ns

module rvCoreTb;

    localparam int          memWords   = 256;
    localparam int          progWords  = 256;
    localparam int          progLen    = 200;
    localparam int          dumpBase   = 1024;
    localparam logic [31:0] ebreakWord = 32'h0010_0073;

    logic             clk;
    logic             reset;
    logic [63:0]      instAddr;
    logic [31:0]      fetchWord;
    rvPkg::wbMaster_t wbOut;
    rvPkg::wbSlave_t  wbIn;
    logic             halt;

    logic [31:0]      progMem [progWords];
    logic [63:0]      dataMem [memWords];
    logic [63:0]      pcTrace [$];
    int               errors;
    int               busCycles;
    logic             active;
    logic             ackNext;
    logic [63:0]      datNext;
    logic             idleNext;
    int               waitLeft;
    rvPkg::wbMaster_t held;

    `include "isaModel.svh"

    rvCore UUT (
        .clk      (clk),
        .reset    (reset),
        .instAddr (instAddr),
        .inst     (fetchWord),
        .wbOut    (wbOut),
        .wbIn     (wbIn),
        .halt     (halt)
    );

    assign fetchWord = (instAddr < progWords * 4) ? progMem[instAddr[9:2]] : 32'h0;

    always #5 clk = ~clk;

    task automatic reportFail(input string msg);
        errors++;
        $display("Fail %0t: %s", $time, msg);
    endtask

    function automatic logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] encS(input logic [11:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [6:0] op);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], op};
    endfunction

    function automatic logic [31:0] encB(input logic [12:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
    endfunction

    function automatic logic [31:0] encJ(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6F};
    endfunction

    // forward-only jumps and branches so the program always reaches the dump
    function automatic logic [31:0] randomInstr(input int idx);
        int          kind;
        int          target;
        int          r;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [1:0]  size;
        logic [11:0] imm;
        logic [11:0] addr;
        logic [19:0] upper;
        logic [12:0] offset;
        kind   = $urandom_range(0, 13);
        rd     = $urandom_range(0, 31);
        rs1    = $urandom_range(0, 31);
        rs2    = $urandom_range(0, 31);
        f3     = $urandom_range(0, 7);
        r      = $urandom_range(0, 5);
        imm    = $urandom;
        upper  = $urandom;
        addr   = $urandom_range(0, 1023);
        target = idx + $urandom_range(1, 8);
        if (target > progLen) target = progLen;
        offset = 13'((target - idx) * 4);
        size   = (kind == 13) ? f3[1:0] : r[1:0];
        addr   = addr & ~((12'd1 << size) - 12'd1);    // natural alignment
        case (kind)
            0:  return {(f3 == 3'd0 && imm[0]) ? 7'h20 : 7'h00, rs2, rs1, f3, rd, 7'h33};
            1: begin
                if (f3[1:0] == 2'b01) imm[11:6] = 6'h00;   // slli or srli
                return encI(imm, rs1, f3, rd, 7'h13);
            end
            2:  return {7'h00, rs2, rs1, 3'd0, rd, 7'h3B};
            3:  return encI(imm, rs1, 3'd0, rd, 7'h1B);
            4:  return {upper, rd, 7'h37};
            5:  return {upper, rd, 7'h17};
            6:  return encJ({8'd0, offset}, rd);
            7:  return encI({target[9:0], 2'b00} | {11'd0, imm[0]}, 5'd0, 3'd0, rd, 7'h67);
            8, 9: return encB(offset, rs2, rs1, 3'(r < 2 ? r : r + 2));
            13: return encS(addr, rs2, 5'd0, {1'b0, size}, 7'h23);
            default: return encI(addr, 5'd0, 3'(r), rd, 7'h03);
        endcase
    endfunction

    task automatic buildProgram();
        foreach (progMem[n]) progMem[n] = ebreakWord;
        for (int n = 0; n < progLen; n++) begin
            progMem[n] = randomInstr(n);
        end
        for (int r = 1; r < 32; r++) begin
            progMem[progLen + r - 1] = encS(12'(dumpBase + 8 * (r - 1)), 5'(r), 5'd0,
                                            3'd3, 7'h23);
        end
        foreach (dataMem[n]) dataMem[n] = {$urandom, $urandom};
    endtask

    task automatic checkHeld();
        if (!wbOut.cyc || !wbOut.stb) reportFail("cyc or stb dropped before ack");
        if (wbOut.adr != held.adr || wbOut.sel != held.sel || wbOut.we != held.we ||
            wbOut.datW != held.datW) begin
            reportFail("bus signals changed before ack");
        end
    endtask

    task automatic startTransfer();
        if (fetchWord[6:0] != 7'h03 && fetchWord[6:0] != 7'h23) begin
            reportFail("bus cycle without a load or store");
        end
        if (wbOut.we != (fetchWord[6:0] == 7'h23)) reportFail("we does not match opcode");
        if (!wbOut.cyc || !wbOut.stb) reportFail("cyc and stb did not rise together");
        if (wbOut.adr >= memWords * 8) reportFail("address outside data memory");
        held     = wbOut;
        active   = 1'b1;
        waitLeft = $urandom_range(0, 3);
        busCycles++;
    endtask

    task automatic finishTransfer();
        storeRec_t   exp;
        logic [63:0] mask;
        checkHeld();
        if (held.we) begin
            for (int k = 0; k < 8; k++) begin
                mask[8*k +: 8] = {8{held.sel[k]}};
            end
            if (expStores.size() == 0) begin
                reportFail("store with none expected");
            end else begin
                exp = expStores.pop_front();
                if (held.adr != exp.adr || held.sel != exp.sel ||
                    (held.datW & mask) != (exp.data & mask)) begin
                    reportFail($sformatf("store %h/%h/%h, model %h/%h/%h", held.adr,
                                         held.sel, held.datW, exp.adr, exp.sel, exp.data));
                end
            end
            for (int k = 0; k < 8; k++) begin
                if (held.sel[k]) dataMem[held.adr[10:3]][8*k +: 8] = held.datW[8*k +: 8];
            end
        end
    endtask

    // slave observes at the falling edge
    always @(negedge clk) begin
        if (reset) begin
            active   = 1'b0;
            ackNext  = 1'b0;
            idleNext = 1'b0;
        end else if (wbIn.ack) begin
            finishTransfer();
            active   = 1'b0;
            ackNext  = 1'b0;
            idleNext = 1'b1;
        end else begin
            if (idleNext && wbOut.cyc) reportFail("bus cycle continued after ack");
            idleNext = 1'b0;
            if (active) begin
                checkHeld();
            end else if (wbOut.cyc || wbOut.stb) begin
                startTransfer();
            end
            if (active && waitLeft == 0) begin
                ackNext = 1'b1;
                datNext = dataMem[held.adr[10:3]];
            end else if (active) begin
                waitLeft--;
            end
        end
    end

    always @(posedge clk) begin
        #1;
        wbIn.ack  = ackNext;
        wbIn.datR = datNext;
    end

    always @(negedge clk) begin
        if (!reset && (pcTrace.size() == 0 || pcTrace[$] != instAddr)) begin
            pcTrace.push_back(instAddr);
        end
    end

    task automatic checkHaltWindow();
        logic [63:0] haltAddr;
        haltAddr = instAddr;
        if (fetchWord != ebreakWord) reportFail("halt raised away from ebreak");
        repeat (20) begin
            @(negedge clk);
            if (!halt) reportFail("halt dropped");
            if (instAddr != haltAddr) reportFail("instAddr moved after halt");
            if (wbOut.cyc || wbOut.stb) reportFail("bus cycle after halt");
        end
    endtask

    task automatic checkResults();
        if (pcTrace.size() != modelTrace.size()) begin
            reportFail($sformatf("pc trace has %0d entries, model %0d", pcTrace.size(),
                                 modelTrace.size()));
        end
        for (int n = 0; n < pcTrace.size() && n < modelTrace.size(); n++) begin
            if (pcTrace[n] != modelTrace[n]) begin
                reportFail($sformatf("pc entry %0d is %h, model %h", n, pcTrace[n],
                                     modelTrace[n]));
                break;
            end
        end
        for (int r = 1; r < 32; r++) begin
            if (dataMem[dumpBase / 8 + r - 1] != modelRegs[r]) begin
                reportFail($sformatf("x%0d dumped %h, model %h", r,
                                     dataMem[dumpBase / 8 + r - 1], modelRegs[r]));
            end
        end
        if (expStores.size() != 0) reportFail("expected stores never seen");
        if (busCycles != modelMemOps) begin
            reportFail($sformatf("%0d bus cycles, model %0d", busCycles, modelMemOps));
        end
    endtask

    initial begin
        int seedValue;
        int cycles;
        seedValue = $urandom(75);
        clk       = 1'b0;
        reset     = 1'b1;
        wbIn      = '0;
        errors    = 0;
        busCycles = 0;
        active    = 1'b0;
        ackNext   = 1'b0;
        datNext   = '0;
        idleNext  = 1'b0;
        waitLeft  = 0;
        buildProgram();
        runModel();
        repeat (4) @(posedge clk);
        #1 reset = 1'b0;
        for (cycles = 0; cycles < 5000 && !halt; cycles++) begin
            @(negedge clk);
        end
        if (!halt) begin
            $display("halt never rose within %0d cycles", cycles);
            errors++;
        end else begin
            checkHaltWindow();
            checkResults();
        end
        $display("%0d errors, %0d bus cycles, %0d pc changes", errors, busCycles,
                 pcTrace.size());
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

/* rvCore.f */
+incdir+sim
common/rvPkg.sv
verilog/decoder.sv
verilog/immGen.sv
verilog/alu.sv
verilog/regFile.sv
verilog/programCounter.sv
verilog/loadStoreUnit.sv
verilog/rvCore.sv
sim/rvCoreTb.sv
